// ==== compile.f ====
hdl/tetris_pkg.sv
hdl/raster_if.sv
hdl/video_timing.sv
hdl/playfield_regs.sv
hdl/cell_locator.sv
hdl/pixel_shader.sv
hdl/tetris_display.sv
testbench/tb_tetris_display_sva.sv
testbench/tb_tetris_display.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the tetris display testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_tetris_display -f compile.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_tetris_display
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0

// ==== testbench/tetris_stimulus.txt ====
# W addr data pslverr | R addr data | P x y colour | F = check probes over the next frame
# addr, data and colour in hex, x and y in decimal
W 00 00000001 0
W 04 00008000 0
W 5C 0000A5A5 0
W 60 00000123 0
R 00 00000001
R 04 00008000
R 5C 0000A5A5
R 60 00000123
# bad address, misaligned address, non-BCD score
W 64 00000001 1
W 62 00000001 1
W 60 000000A5 1
R 60 00000123
R 64 00000000
P 10 10 00ff00
P 30 10 202020
P 310 30 00ff00
P 10 470 00ff00
P 30 470 202020
P 320 0 00ff00
P 410 30 00ff00
P 390 30 202020
P 510 50 00ff00
P 470 50 202020
P 590 50 00ff00
P 550 50 202020
P 570 70 00ff00
P 450 10 202020
P 630 470 202020
P 380 130 202020
F
W 00 00000002 0
W 60 00000908 0
R 60 00000908
P 10 10 202020
P 30 10 00ff00
P 430 90 00ff00
P 390 90 202020
P 470 30 00ff00
P 490 70 202020
P 570 70 00ff00
P 320 200 00ff00
F

// ==== testbench/tb_tetris_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tetris_display
  import tetris_pkg::*;
();

  localparam int    H_ACTIVE  = 640;
  localparam int    V_ACTIVE  = 480;
  localparam int    H_TOTAL   = 640 + 16 + 96 + 48;
  localparam int    V_TOTAL   = 480 + 10 + 2 + 33;
  localparam int    CLK_NS    = 4;
  localparam bgr_t  BG_COLOR  = 24'h202020;
  localparam string STIM_FILE = "testbench/tetris_stimulus.txt";

  logic        iVGA_CLK = 1'b0;
  logic        iRST_n;
  logic [7:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  wire  [31:0] prdata;
  wire         pready;
  wire         pslverr;
  wire         hs;
  wire         vs;
  wire         blank_n;
  wire  [7:0]  r_data;
  wire  [7:0]  g_data;
  wire  [7:0]  b_data;

  // raster tracker state
  // probes are keyed by y*1024 + x
  bgr_t   probes [int];
  bgr_t   pix;
  int     x_cnt     = 0;
  int     y_cnt     = 0;
  int     hits      = 0;
  logic   blank_q   = 1'b0;
  logic   vs_q      = 1'b1;
  logic   arm_req   = 1'b0;
  logic   capturing = 1'b0;
  logic   frame_done = 1'b0;
  longint watch_ns  = 0;

  always #2 iVGA_CLK = ~iVGA_CLK;

  tetris_display #(
    .BG_COLOR (BG_COLOR)
  ) tetris_display_i (
    .iVGA_CLK (iVGA_CLK),
    .iRST_n   (iRST_n),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .hs       (hs),
    .vs       (vs),
    .blank_n  (blank_n),
    .r_data   (r_data),
    .g_data   (g_data),
    .b_data   (b_data)
  );

  ////////////////////////////////////////
  // checks

  task automatic stop_run(string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_color(bgr_t got, bgr_t exp, string what);
    if (got !== exp) begin
      stop_run($sformatf("mismatch at %0t: %s colour %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_data(logic [31:0] got, logic [31:0] exp, string what);
    if (got !== exp) begin
      stop_run($sformatf("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_err(logic got, logic exp, string what);
    if (got !== exp) begin
      stop_run($sformatf("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  ////////////////////////////////////////
  // APB driver and frame control

  task automatic drive_edge();
    @(posedge iVGA_CLK);
    #1;
  endtask

  task automatic apb_transfer(
    input  logic        write,
    input  logic [7:0]  addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        err
  );
    drive_edge();
    paddr   = addr;
    pwdata  = wdata;
    pwrite  = write;
    psel    = 1'b1;
    penable = 1'b0;
    drive_edge();
    penable = 1'b1;
    @(negedge iVGA_CLK);
    rdata = prdata;
    err   = pslverr;
    check_err(pready, 1'b1, "pready in the access cycle");
    drive_edge();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // probes are checked over the whole next frame
  task automatic run_frame();
    drive_edge();
    frame_done = 1'b0;
    arm_req    = 1'b1;
    wait (frame_done);
    probes.delete();
  endtask

  // raster seen from the ports only
  always @(negedge iVGA_CLK) begin
    if (iRST_n) begin
      pix = {b_data, g_data, r_data};
      if (blank_n) begin
        if (x_cnt == 0 && y_cnt == 0 && arm_req) begin
          arm_req   = 1'b0;
          capturing = 1'b1;
          hits      = 0;
        end
        if (x_cnt == int'(DIVIDER_X)) begin
          check_color(pix, FILL_COLOR, $sformatf("divider in line %0d", y_cnt));
        end
        if (capturing && probes.exists(y_cnt * 1024 + x_cnt)) begin
          check_color(pix, probes[y_cnt * 1024 + x_cnt],
                      $sformatf("probe (%0d,%0d)", x_cnt, y_cnt));
          hits++;
        end
        x_cnt++;
      end else begin
        check_color(pix, '0, "blanked pixel");
        if (blank_q) begin
          check_data(32'(x_cnt), 32'(H_ACTIVE), "active pixels in a line");
          x_cnt = 0;
          y_cnt++;
        end
      end
      if (!vs && vs_q) begin
        check_data(32'(y_cnt), 32'(V_ACTIVE), "active lines in a frame");
        y_cnt = 0;
        if (capturing) begin
          check_data(32'(hits), 32'(probes.num()), "probes reached in the frame");
          capturing  = 1'b0;
          frame_done = 1'b1;
        end
      end
      blank_q = blank_n;
      vs_q    = vs;
    end
  end

  initial begin
    wait (watch_ns > 0);
    #(watch_ns);
    stop_run($sformatf("timeout: the run did not finish within %0d ns", watch_ns));
  end

  ////////////////////////////////////////
  // stimulus

  initial begin
    int            fd;
    int            code;
    int            frames;
    int            px;
    int            py;
    logic [7:0]    ch;
    logic [7:0]    addr;
    logic [31:0]   data;
    logic [31:0]   got_data;
    logic          err;
    logic          got_err;
    bgr_t          pc;
    logic [8*200-1:0] line;

    iRST_n  = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;

    // first pass sizes the watchdog
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      stop_run("cannot open the stimulus file");
    end
    frames = 0;
    while ($fscanf(fd, " %c", ch) == 1) begin
      if (ch == "F") begin
        frames++;
      end else begin
        code = $fgets(line, fd);
      end
    end
    $fclose(fd);
    watch_ns = longint'(frames + 1) * H_TOTAL * V_TOTAL * CLK_NS;

    @(negedge iVGA_CLK);
    check_err(hs, 1'b1, "hs in reset");
    check_err(vs, 1'b1, "vs in reset");
    check_err(blank_n, 1'b0, "blank_n in reset");
    check_err(pslverr, 1'b0, "pslverr in reset");
    check_data(prdata, 32'h0, "prdata in reset");
    check_color({b_data, g_data, r_data}, '0, "colour in reset");
    @(posedge iVGA_CLK);
    #1;
    iRST_n = 1'b1;

    fd = $fopen(STIM_FILE, "r");
    while ($fscanf(fd, " %c", ch) == 1) begin
      if (ch == "W") begin
        code = $fscanf(fd, "%h %h %h", addr, data, err);
        if (code != 3) begin
          stop_run("malformed write line in the stimulus file");
        end
        apb_transfer(1'b1, addr, data, got_data, got_err);
        check_err(got_err, err, $sformatf("pslverr on write to %h", addr));
      end else if (ch == "R") begin
        code = $fscanf(fd, "%h %h", addr, data);
        if (code != 2) begin
          stop_run("malformed read line in the stimulus file");
        end
        apb_transfer(1'b0, addr, 32'h0, got_data, got_err);
        check_data(got_data, data, $sformatf("read data at %h", addr));
      end else if (ch == "P") begin
        code = $fscanf(fd, "%d %d %h", px, py, pc);
        if (code != 3) begin
          stop_run("malformed probe line in the stimulus file");
        end
        probes[py * 1024 + px] = pc;
      end else if (ch == "F") begin
        run_frame();
      end else begin
        code = $fgets(line, fd);
      end
    end
    $fclose(fd);

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/tb_tetris_display_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tetris_display_sva #(
  parameter int H_SYNC = 96
) (
  input wire iVGA_CLK,
  input wire iRST_n,
  input wire hs,
  input wire vs,
  input wire blank_n,
  input wire psel,
  input wire penable,
  input wire pready
);

  // cycles of the current hs low pulse
  int low_cnt;

  always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
    if (!iRST_n) begin
      low_cnt <= 0;
    end else if (!hs) begin
      low_cnt <= low_cnt + 1;
    end else begin
      low_cnt <= 0;
    end
  end

  hs_not_too_long: assert property (@(posedge iVGA_CLK) disable iff (!iRST_n)
    !hs |-> (low_cnt < H_SYNC))
    else $error("hs stayed low for more than %0d cycles", H_SYNC);

  hs_pulse_width: assert property (@(posedge iVGA_CLK) disable iff (!iRST_n)
    $rose(hs) |-> (low_cnt == H_SYNC))
    else $error("hs low pulse lasted %0d cycles instead of %0d", low_cnt, H_SYNC);

  no_video_in_vsync: assert property (@(posedge iVGA_CLK) disable iff (!iRST_n)
    !vs |-> !blank_n)
    else $error("blank_n high during vertical sync");

  apb_zero_wait: assert property (@(posedge iVGA_CLK) disable iff (!iRST_n)
    (psel && penable) |-> pready)
    else $error("pready low in an APB access cycle");

endmodule

bind tetris_display tb_tetris_display_sva #(
  .H_SYNC (H_SYNC)
) tetris_display_sva_i (
  .iVGA_CLK (iVGA_CLK),
  .iRST_n   (iRST_n),
  .hs       (hs),
  .vs       (vs),
  .blank_n  (blank_n),
  .psel     (psel),
  .penable  (penable),
  .pready   (pready)
);

`default_nettype wire

// ==== hdl/tetris_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module tetris_display
  import tetris_pkg::*;
#(
  parameter int   H_ACTIVE = 640,
  parameter int   H_FRONT  = 16,
  parameter int   H_SYNC   = 96,
  parameter int   H_BACK   = 48,
  parameter int   V_ACTIVE = 480,
  parameter int   V_FRONT  = 10,
  parameter int   V_SYNC   = 2,
  parameter int   V_BACK   = 33,
  parameter bgr_t BG_COLOR = 24'h202020
) (
  input  wire         iVGA_CLK,
  input  wire         iRST_n,
  input  wire  [7:0]  paddr,
  input  wire         psel,
  input  wire         penable,
  input  wire         pwrite,
  input  wire  [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        hs,
  output logic        vs,
  output logic        blank_n,
  output logic [7:0]  r_data,
  output logic [7:0]  g_data,
  output logic [7:0]  b_data
);

  board_t       board;
  digit_t [2:0] digits;
  bgr_t         color;

  raster_if ras_t ();
  raster_if ras_c ();

  ////////////////////////////////////////
  // raster pipeline, two stages behind the counters

  video_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) video_timing_i (
    .iVGA_CLK (iVGA_CLK),
    .iRST_n   (iRST_n),
    .ras      (ras_t)
  );

  cell_locator cell_locator_i (
    .iVGA_CLK (iVGA_CLK),
    .iRST_n   (iRST_n),
    .ras_in   (ras_t),
    .ras_out  (ras_c)
  );

  pixel_shader #(
    .BG_COLOR (BG_COLOR)
  ) pixel_shader_i (
    .iVGA_CLK (iVGA_CLK),
    .iRST_n   (iRST_n),
    .ras_in   (ras_c),
    .board    (board),
    .digits   (digits),
    .hs       (hs),
    .vs       (vs),
    .blank_n  (blank_n),
    .color    (color)
  );

  ////////////////////////////////////////
  // host side

  playfield_regs playfield_regs_i (
    .iVGA_CLK (iVGA_CLK),
    .iRST_n   (iRST_n),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .board    (board),
    .digits   (digits)
  );

  assign b_data = color[23:16];
  assign g_data = color[15:8];
  assign r_data = color[7:0];

endmodule

`default_nettype wire

// ==== hdl/pixel_shader.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_shader
  import tetris_pkg::*;
#(
  parameter bgr_t BG_COLOR = 24'h202020
) (
  input  wire          iVGA_CLK,
  input  wire          iRST_n,
  raster_if.dst        ras_in,
  input  wire board_t  board,
  input  wire digit_t [2:0] digits,
  output logic         hs,
  output logic         vs,
  output logic         blank_n,
  output bgr_t         color
);

  localparam int ROW_W = $clog2(BOARD_ROWS);
  localparam int COL_W = $clog2(BOARD_COLS);

  coord_t ccol;
  coord_t crow;
  logic   lit;
  bgr_t   next_color;

  // glyph bit of digit d at cell (c, r), box starting at cell column c0
  function automatic logic digit_lit(digit_t d, coord_t c0, coord_t c, coord_t r);
    coord_t lcol;
    coord_t lrow;
    coord_t idx;
    font_t  glyph;
    lcol  = c - c0;
    lrow  = r - DIGIT_ROW0;
    idx   = lrow * DIGIT_W + lcol;
    glyph = FONT[d];
    return glyph[idx[3:0]];
  endfunction

  assign ccol = ras_in.cell_col;
  assign crow = ras_in.cell_row;

  always_comb begin
    case (ras_in.in_region)
      REG_BOARD:   lit = board[crow[ROW_W-1:0]][ccol[COL_W-1:0]];
      REG_DIVIDER: lit = 1'b1;
      REG_DIGIT0:  lit = digit_lit(digits[0], DIGIT_COL0[0], ccol, crow);
      REG_DIGIT1:  lit = digit_lit(digits[1], DIGIT_COL0[1], ccol, crow);
      REG_DIGIT2:  lit = digit_lit(digits[2], DIGIT_COL0[2], ccol, crow);
      default:     lit = 1'b0;
    endcase
  end

  // blanked pixels are always region none, so never lit
  always_comb begin
    if (lit) begin
      next_color = FILL_COLOR;
    end else if (ras_in.blank_n) begin
      next_color = BG_COLOR;
    end else begin
      next_color = '0;
    end
  end

  always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
    if (!iRST_n) begin
      hs      <= 1'b1;
      vs      <= 1'b1;
      blank_n <= 1'b0;
      color   <= '0;
    end else begin
      hs      <= ras_in.hs;
      vs      <= ras_in.vs;
      blank_n <= ras_in.blank_n;
      color   <= next_color;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/cell_locator.sv ====
`timescale 1ns/1ps
`default_nettype none

module cell_locator
  import tetris_pkg::*;
(
  input wire    iVGA_CLK,
  input wire    iRST_n,
  raster_if.dst ras_in,
  raster_if.src ras_out
);

  coord_t  col;
  coord_t  row;
  region_e region;

  // inside the 3x5 box whose left cell column is c0
  function automatic logic in_digit(coord_t c, coord_t r, coord_t c0);
    return (c >= c0) && (c < c0 + DIGIT_W) &&
           (r >= DIGIT_ROW0) && (r < DIGIT_ROW0 + DIGIT_H);
  endfunction

  assign col = ras_in.x / CELL_PX;
  assign row = ras_in.y / CELL_PX;

  always_comb begin
    if (!ras_in.blank_n) begin
      region = REG_NONE;
    end else if (ras_in.x == DIVIDER_X) begin
      region = REG_DIVIDER;
    end else if ((ras_in.x < DIVIDER_X) && (row < coord_t'(BOARD_ROWS))) begin
      region = REG_BOARD;
    end else if (in_digit(col, row, DIGIT_COL0[0])) begin
      region = REG_DIGIT0;
    end else if (in_digit(col, row, DIGIT_COL0[1])) begin
      region = REG_DIGIT1;
    end else if (in_digit(col, row, DIGIT_COL0[2])) begin
      region = REG_DIGIT2;
    end else begin
      region = REG_NONE;
    end
  end

  // sync and region
  always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
    if (!iRST_n) begin
      ras_out.hs        <= 1'b1;
      ras_out.vs        <= 1'b1;
      ras_out.blank_n   <= 1'b0;
      ras_out.in_region <= REG_NONE;
    end else begin
      ras_out.hs        <= ras_in.hs;
      ras_out.vs        <= ras_in.vs;
      ras_out.blank_n   <= ras_in.blank_n;
      ras_out.in_region <= region;
    end
  end

  always_ff @(posedge iVGA_CLK) begin
    ras_out.x        <= ras_in.x;
    ras_out.y        <= ras_in.y;
    ras_out.cell_col <= col;
    ras_out.cell_row <= row;
  end

endmodule

`default_nettype wire

// ==== hdl/playfield_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module playfield_regs
  import tetris_pkg::*;
(
  input  wire          iVGA_CLK,
  input  wire          iRST_n,
  input  wire  [7:0]   paddr,
  input  wire          psel,
  input  wire          penable,
  input  wire          pwrite,
  input  wire  [31:0]  pwdata,
  output logic [31:0]  prdata,
  output logic         pready,
  output logic         pslverr,
  output board_t       board,
  output digit_t [2:0] digits
);

  localparam int ROW_W = $clog2(BOARD_ROWS);

  logic             access;
  logic             is_score;
  logic             addr_bad;
  logic             bcd_bad;
  logic             wr_en;
  logic [ROW_W-1:0] row_idx;

  ////////////////////////////////////////
  // decode

  assign access   = psel && penable;
  assign is_score = (paddr == ADDR_SCORE);
  assign addr_bad = (paddr[1:0] != 2'b00) || (paddr > ADDR_SCORE);
  assign bcd_bad  = (pwdata[11:8] > 4'd9) || (pwdata[7:4] > 4'd9) ||
                    (pwdata[3:0] > 4'd9);
  assign row_idx  = paddr[ROW_W+1:2];

  // zero wait states
  assign pready  = 1'b1;
  assign pslverr = access && (addr_bad || (pwrite && is_score && bcd_bad));
  assign wr_en   = access && pwrite && !pslverr;

  // read data is ready from the setup cycle on
  always_comb begin
    prdata = '0;
    if (psel && !pwrite && !addr_bad) begin
      if (is_score) begin
        prdata = {20'd0, digits[0], digits[1], digits[2]};
      end else begin
        prdata = 32'(board[row_idx]);
      end
    end
  end

  ////////////////////////////////////////
  // storage

  // digits[0] is the hundreds, leftmost on screen
  always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
    if (!iRST_n) begin
      board  <= '0;
      digits <= '0;
    end else if (wr_en) begin
      if (is_score) begin
        digits[0] <= pwdata[11:8];
        digits[1] <= pwdata[7:4];
        digits[2] <= pwdata[3:0];
      end else begin
        board[row_idx] <= pwdata[BOARD_COLS-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/video_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_timing
  import tetris_pkg::*;
#(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input wire    iVGA_CLK,
  input wire    iRST_n,
  raster_if.src ras
);

  // line layout is active, front porch, sync, back porch
  localparam coord_t H_ACT      = coord_t'(H_ACTIVE);
  localparam coord_t H_SYNC_ON  = coord_t'(H_ACTIVE + H_FRONT);
  localparam coord_t H_SYNC_OFF = coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
  localparam coord_t H_LAST     = coord_t'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);

  localparam coord_t V_ACT      = coord_t'(V_ACTIVE);
  localparam coord_t V_SYNC_ON  = coord_t'(V_ACTIVE + V_FRONT);
  localparam coord_t V_SYNC_OFF = coord_t'(V_ACTIVE + V_FRONT + V_SYNC);
  localparam coord_t V_LAST     = coord_t'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);

  coord_t h_cnt;
  coord_t v_cnt;
  logic   line_end;
  logic   frame_end;

  assign line_end  = (h_cnt == H_LAST);
  assign frame_end = line_end && (v_cnt == V_LAST);

  always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
    if (!iRST_n) begin
      h_cnt <= '0;
    end else if (line_end) begin
      h_cnt <= '0;
    end else begin
      h_cnt <= h_cnt + 10'd1;
    end
  end

  always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
    if (!iRST_n) begin
      v_cnt <= '0;
    end else if (frame_end) begin
      v_cnt <= '0;
    end else if (line_end) begin
      v_cnt <= v_cnt + 10'd1;
    end
  end

  assign ras.x       = h_cnt;
  assign ras.y       = v_cnt;
  assign ras.hs      = !((h_cnt >= H_SYNC_ON) && (h_cnt < H_SYNC_OFF));
  assign ras.vs      = !((v_cnt >= V_SYNC_ON) && (v_cnt < V_SYNC_OFF));
  assign ras.blank_n = (h_cnt < H_ACT) && (v_cnt < V_ACT);

  // region and cell are filled in by the locator
  assign ras.in_region = REG_NONE;
  assign ras.cell_col  = '0;
  assign ras.cell_row  = '0;

endmodule

`default_nettype wire

// ==== hdl/raster_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one pixel on its way down the raster pipeline
interface raster_if
  import tetris_pkg::*;
();

  coord_t  x;
  coord_t  y;
  logic    hs;
  logic    vs;
  logic    blank_n;
  region_e in_region;
  coord_t  cell_col;
  coord_t  cell_row;

  modport src (
    output x, y, hs, vs, blank_n, in_region, cell_col, cell_row
  );

  modport dst (
    input x, y, hs, vs, blank_n, in_region, cell_col, cell_row
  );

endinterface

`default_nettype wire

// ==== hdl/tetris_pkg.sv ====
`default_nettype none

package tetris_pkg;

  ////////////////////////////////////////
  // screen geometry

  typedef logic [9:0] coord_t;

  localparam coord_t CELL_PX    = 10'd20;
  localparam coord_t DIVIDER_X  = 10'd320;
  localparam int     BOARD_COLS = 16;
  localparam int     BOARD_ROWS = 24;

  // score boxes, counted in cells
  localparam coord_t DIGIT_COL0 [3] = '{10'd19, 10'd23, 10'd27};
  localparam coord_t DIGIT_ROW0     = 10'd1;
  localparam coord_t DIGIT_W        = 10'd3;
  localparam coord_t DIGIT_H        = 10'd5;

  ////////////////////////////////////////
  // colour and board storage

  // blue in the high byte, red in the low byte
  typedef logic [23:0] bgr_t;

  localparam bgr_t FILL_COLOR = 24'h00ff00;

  typedef logic [BOARD_COLS-1:0] board_row_t;
  typedef board_row_t [BOARD_ROWS-1:0] board_t;
  typedef logic [3:0] digit_t;

  // board rows sit at 4*n below this
  localparam logic [7:0] ADDR_SCORE = 8'h60;

  typedef enum logic [2:0] {
    REG_NONE,
    REG_BOARD,
    REG_DIVIDER,
    REG_DIGIT0,
    REG_DIGIT1,
    REG_DIGIT2
  } region_e;

  ////////////////////////////////////////
  // 3x5 digit glyphs, bit (row*3 + col), each row is {col2, col1, col0}

  typedef logic [14:0] font_t;

  localparam font_t FONT [10] = '{
    15'b111_101_101_101_111,
    15'b010_010_010_010_010,
    15'b111_001_111_100_111,
    15'b111_100_111_100_111,
    15'b100_100_111_101_101,
    15'b111_100_111_001_111,
    15'b111_101_111_001_111,
    15'b100_100_100_100_111,
    15'b111_101_111_101_111,
    15'b111_100_111_101_111
  };

endpackage

`default_nettype wire
